/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = capture_tb
FILELIST   = capture_sdram.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* capture_sdram.f */
hw/capture_pkg.sv
hw/sample_buffer.sv
hw/capture_scheduler.sv
hw/sdram_store.sv
hw/readout_shifter.sv
hw/capture_top.sv
dv/tb_clock_gen.sv
dv/capture_sva.sv
dv/capture_tb.sv

/* dv/capture_sva.sv */
`timescale 1ns/1ps

module capture_sva
   import capture_pkg::*;
(
   input logic           clk,
   input logic           rst,
   input logic           cmd_enable,
   input logic           cmd_ready,
   input capture_phase_e phase,
   input logic           done
);

   int sva_errors = 0;   // failed assertion count

   // a command only goes out while the store is ready
   enable_needs_ready: assert property (@(posedge clk) disable iff (rst)
      cmd_enable |-> cmd_ready)
   else
   begin
      $error("cmd_enable pulsed while cmd_ready was low");
      sva_errors++;
   end

   enable_is_pulse: assert property (@(posedge clk) disable iff (rst)
      cmd_enable |=> !cmd_enable)
   else
   begin
      $error("cmd_enable held high for more than one cycle");
      sva_errors++;
   end

   // done is sticky until reset
   done_never_falls: assert property (@(posedge clk) disable iff (rst)
      done |=> done)
   else
   begin
      $error("done fell after it was set");
      sva_errors++;
   end

endmodule

bind capture_scheduler capture_sva u_sva
(
   .clk        (clk),
   .rst        (rst),
   .cmd_enable (cmd_enable),
   .cmd_ready  (cmd_ready),
   .phase      (phase),
   .done       (done)
);

/* dv/capture_tb.sv */
`timescale 1ns/1ps

module capture_tb
   import capture_pkg::*;
();

   localparam int SDRAM_AW  = 6;
   localparam int NUM_WORDS = 2**(SDRAM_AW-1);
   localparam int NUM_EXTRA = 8;   // driven after the region is full

   logic                clk;
   logic                rst;
   logic                sample_valid;
   logic [SAMPLE_W-1:0] sample_data;
   logic                sdo;
   logic                sdo_valid;
   capture_phase_e      phase;
   logic                done;

   integer              seed = 23202;
   logic [SAMPLE_W-1:0] driven [$];   // samples in arrival order
   logic [WORD_W-1:0]   shift_acc = '0;
   int                  run_len = 0;
   int                  words_seen = 0;
   int                  word_errors = 0;
   int                  phase_errors = 0;
   int                  flag_errors = 0;
   int                  count_errors = 0;
   int                  other_errors = 0;

   tb_clock_gen u_clk (.clk(clk));

   capture_top #(.SDRAM_AW(SDRAM_AW), .SDRAM_LATENCY(3)) uut
   (
      .clk          (clk),
      .rst          (rst),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .sdo          (sdo),
      .sdo_valid    (sdo_valid),
      .phase        (phase),
      .done         (done)
   );

   // i-th sample as it should come back from the region
   function automatic logic [WORD_W-1:0] expected_word(input int i);
      logic [WORD_W-1:0] w;
      w = '0;
      w[SAMPLE_W-1:0] = driven[i];
      return w;
   endfunction

   task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                             input logic [WORD_W-1:0] act);
      if (act !== exp)
      begin
         word_errors++;
         $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
      end
   endtask

   task automatic check_phase(input string name, input capture_phase_e exp,
                              input capture_phase_e act);
      if (act !== exp)
      begin
         phase_errors++;
         $display("[FAIL] %s expected %s actual %s", name, exp.name(), act.name());
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         flag_errors++;
         $display("[FAIL] %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp)
      begin
         count_errors++;
         $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      end
   endtask

   // one sample strobe, optionally followed by 0 to 5 idle cycles
   task automatic send_sample(input bit spaced);
      logic [SAMPLE_W-1:0] val;
      int                  gap;
      val = SAMPLE_W'($random(seed));
      gap = spaced ? int'($unsigned($random(seed)) % 6) : 0;
      @(negedge clk);
      sample_valid = 1'b1;
      sample_data  = val;
      driven.push_back(val);
      repeat (gap)
      begin
         @(negedge clk);
         sample_valid = 1'b0;
      end
   endtask

   task automatic wait_for_replay(output bit ok);
      ok = 1'b0;
      for (int n = 0; n < 2000 && !ok; n++)
      begin
         @(negedge clk);
         ok = (phase == PH_TX_READ) || (phase == PH_TX_IDLE) || (phase == PH_FINISHED);
      end
      if (!ok)
      begin
         other_errors++;
         $display("timeout: the scheduler never reached the replay phases");
      end
   endtask

   task automatic wait_for_words(output bit ok);
      ok = 1'b0;
      for (int n = 0; n < 5000 && !ok; n++)
      begin
         @(posedge clk);   // words_seen only moves on the falling edge
         ok = (words_seen >= NUM_WORDS);
      end
      if (!ok)
      begin
         other_errors++;
         $display("timeout: only %0d of %0d words were replayed", words_seen, NUM_WORDS);
      end
   endtask

   // rebuild words from the serial stream, msb first
   always @(negedge clk)
   begin
      if (!rst && sdo_valid)
      begin
         shift_acc = {shift_acc[WORD_W-2:0], sdo};
         run_len   = run_len + 1;
      end
      else if (run_len != 0)
      begin
         check_count($sformatf("sdo_valid run of word %0d", words_seen), WORD_W, run_len);
         if (words_seen < NUM_WORDS)
         begin
            check_word($sformatf("word %0d", words_seen), expected_word(words_seen), shift_acc);
         end
         else
         begin
            other_errors++;
            $display("unexpected word 0x%08h after the region was replayed", shift_acc);
         end
         words_seen++;
         run_len = 0;
      end
   end

   initial
   begin
      bit ok;
      int late_valid;
      int total;
      rst          = 1'b1;
      sample_valid = 1'b0;
      sample_data  = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_phase("phase after reset", PH_WAITING, phase);
      check_flag("sdo_valid after reset", 1'b0, sdo_valid);
      check_flag("done after reset", 1'b0, done);

      // back-to-back burst first, then random spacing
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         send_sample(i >= 8);
      end
      @(negedge clk);
      sample_valid = 1'b0;

      wait_for_replay(ok);
      if (ok)
      begin
         for (int i = 0; i < NUM_EXTRA; i++)
         begin
            send_sample(1'b1);
         end
         @(negedge clk);
         sample_valid = 1'b0;
         wait_for_words(ok);
      end
      if (ok)
      begin
         @(negedge clk);
         check_flag("done after replay", 1'b1, done);
         check_phase("phase after replay", PH_FINISHED, phase);
         late_valid = 0;
         repeat (200)
         begin
            @(negedge clk);
            late_valid += int'(sdo_valid);
         end
         check_count("sdo_valid cycles after the last word", 0, late_valid);
         check_count("words replayed", NUM_WORDS, words_seen);
      end

      total = word_errors + phase_errors + flag_errors + count_errors + other_errors
              + uut.u_scheduler.u_sva.sva_errors;
      $display("errors: word %0d, phase %0d, flag %0d, count %0d, other %0d, assertion %0d",
               word_errors, phase_errors, flag_errors, count_errors, other_errors,
               uut.u_scheduler.u_sva.sva_errors);
      if (total == 0)
      begin
         $display("All tests passed!");
      end
      else
      begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
#(
   parameter real PERIOD_NS = 10.0
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;   // 50% duty
   end

endmodule

/* hw/capture_pkg.sv */
package capture_pkg;

   // acquisition and storage widths
   localparam int SAMPLE_W = 24;
   localparam int WORD_W   = 32;   // samples are stored zero-extended
   localparam int BUF_AW   = 9;    // 512-entry block buffer

   // scheduler phases
   typedef enum logic [2:0]
   {
      PH_WAITING      = 3'd0,
      PH_BUF_TO_SDRAM = 3'd1,
      PH_TX_READ      = 3'd2,
      PH_TX_IDLE      = 3'd3,
      PH_FINISHED     = 3'd4
   } capture_phase_e;

   // command port opcode
   typedef enum logic
   {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } sdram_op_e;

endpackage

/* hw/capture_scheduler.sv */
`timescale 1ns/1ps

module capture_scheduler
   import capture_pkg::*;
#(
   parameter int SDRAM_AW = 6
)
(
   input  logic                clk,
   input  logic                rst,

   // sample buffer side
   input  logic [BUF_AW-1:0]   buf_wr_addr,
   input  logic [SAMPLE_W-1:0] buf_rd_data,
   output logic [BUF_AW-1:0]   buf_rd_addr,

   // command port to the SDRAM store
   input  logic                cmd_ready,
   output logic                cmd_enable,
   output sdram_op_e           cmd_op,
   output logic [SDRAM_AW-2:0] cmd_addr,
   output logic [WORD_W-1:0]   cmd_wdata,

   // readout pacing
   input  logic                read_complete,

   output capture_phase_e      phase,
   output logic                done
);

   // both pointers are one bit wider than the region, top bit means wrapped once
   logic [SDRAM_AW-1:0] wr_ptr;
   logic [SDRAM_AW-1:0] rd_ptr;

   logic issue_wr;
   logic issue_rd;
   logic buf_pending;

   assign buf_pending = (buf_rd_addr != buf_wr_addr);
   assign issue_wr    = (phase == PH_BUF_TO_SDRAM) && cmd_ready;
   assign issue_rd    = (phase == PH_TX_READ) && cmd_ready;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         phase       <= PH_WAITING;
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         buf_rd_addr <= '0;
         cmd_enable  <= 1'b0;
         cmd_op      <= OP_READ;
         done        <= 1'b0;
      end
      else
      begin
         cmd_enable <= 1'b0;   // enable is a one-cycle pulse
         case (phase)
            PH_WAITING:
            begin
               if (wr_ptr[SDRAM_AW-1])
               begin
                  phase <= PH_TX_READ;   // region full, start replay
               end
               else if (buf_pending)
               begin
                  // buffer read data is valid by the time the write is issued
                  phase <= PH_BUF_TO_SDRAM;
               end
            end
            PH_BUF_TO_SDRAM:
            begin
               if (issue_wr)
               begin
                  cmd_enable  <= 1'b1;
                  cmd_op      <= OP_WRITE;
                  wr_ptr      <= wr_ptr + 1'b1;
                  buf_rd_addr <= buf_rd_addr + 1'b1;
                  phase       <= PH_WAITING;   // gives the idle cycle after the pulse
               end
            end
            PH_TX_READ:
            begin
               if (issue_rd)
               begin
                  cmd_enable <= 1'b1;
                  cmd_op     <= OP_READ;
                  rd_ptr     <= rd_ptr + 1'b1;
                  phase      <= PH_TX_IDLE;
               end
            end
            PH_TX_IDLE:
            begin
               if (rd_ptr[SDRAM_AW-1])
               begin
                  phase <= PH_FINISHED;
                  done  <= 1'b1;
               end
               else if (read_complete)
               begin
                  phase <= PH_TX_READ;   // shifter drained, next word
               end
            end
            PH_FINISHED:
            begin
               done <= 1'b1;   // parked until reset
            end
            default:
            begin
               phase <= PH_WAITING;
            end
         endcase
      end
   end

   // command payload, only meaningful while cmd_enable is high
   always_ff @(posedge clk)
   begin
      if (issue_wr)
      begin
         cmd_addr  <= wr_ptr[SDRAM_AW-2:0];
         cmd_wdata <= {{(WORD_W-SAMPLE_W){1'b0}}, buf_rd_data};
      end
      else if (issue_rd)
      begin
         cmd_addr <= rd_ptr[SDRAM_AW-2:0];
      end
   end

endmodule

/* hw/capture_top.sv */
`timescale 1ns/1ps

module capture_top
   import capture_pkg::*;
#(
   parameter int SDRAM_AW      = 6,   // includes the full bit
   parameter int SDRAM_LATENCY = 3
)
(
   input  logic                clk,
   input  logic                rst,
   input  logic                sample_valid,
   input  logic [SAMPLE_W-1:0] sample_data,
   output logic                sdo,
   output logic                sdo_valid,
   output capture_phase_e      phase,
   output logic                done
);

   logic [BUF_AW-1:0]   buf_wr_addr;
   logic [BUF_AW-1:0]   buf_rd_addr;
   logic [SAMPLE_W-1:0] buf_rd_data;

   // command port
   logic                cmd_ready;
   logic                cmd_enable;
   sdram_op_e           cmd_op;
   logic [SDRAM_AW-2:0] cmd_addr;
   logic [WORD_W-1:0]   cmd_wdata;

   logic                rd_valid;
   logic [WORD_W-1:0]   rd_data;
   logic                read_complete;

   sample_buffer u_buffer
   (
      .clk          (clk),
      .rst          (rst),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .buf_rd_addr  (buf_rd_addr),
      .buf_wr_addr  (buf_wr_addr),
      .buf_rd_data  (buf_rd_data)
   );

   capture_scheduler #(.SDRAM_AW(SDRAM_AW)) u_scheduler
   (
      .clk           (clk),
      .rst           (rst),
      .buf_wr_addr   (buf_wr_addr),
      .buf_rd_data   (buf_rd_data),
      .buf_rd_addr   (buf_rd_addr),
      .cmd_ready     (cmd_ready),
      .cmd_enable    (cmd_enable),
      .cmd_op        (cmd_op),
      .cmd_addr      (cmd_addr),
      .cmd_wdata     (cmd_wdata),
      .read_complete (read_complete),
      .phase         (phase),
      .done          (done)
   );

   sdram_store #(.SDRAM_AW(SDRAM_AW), .SDRAM_LATENCY(SDRAM_LATENCY)) u_sdram
   (
      .clk        (clk),
      .rst        (rst),
      .cmd_enable (cmd_enable),
      .cmd_op     (cmd_op),
      .cmd_addr   (cmd_addr),
      .cmd_wdata  (cmd_wdata),
      .cmd_ready  (cmd_ready),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data)
   );

   readout_shifter u_readout
   (
      .clk           (clk),
      .rst           (rst),
      .rd_valid      (rd_valid),   // no back-pressure, scheduler paces the reads
      .rd_data       (rd_data),
      .sdo           (sdo),
      .sdo_valid     (sdo_valid),
      .read_complete (read_complete)
   );

endmodule

/* hw/readout_shifter.sv */
`timescale 1ns/1ps

module readout_shifter
   import capture_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              rd_valid,
   input  logic [WORD_W-1:0] rd_data,
   output logic              sdo,
   output logic              sdo_valid,
   output logic              read_complete
);

   localparam int CNT_W = $clog2(WORD_W+1);

   logic [WORD_W-1:0] shift_reg;
   logic [CNT_W-1:0]  bit_cnt;   // bits still to send

   assign sdo       = shift_reg[WORD_W-1];   // msb first
   assign sdo_valid = (bit_cnt != '0);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         bit_cnt       <= '0;
         read_complete <= 1'b0;
      end
      else
      begin
         read_complete <= 1'b0;
         if (rd_valid)
         begin
            bit_cnt <= CNT_W'(WORD_W);
         end
         else if (sdo_valid)
         begin
            bit_cnt <= bit_cnt - 1'b1;
            // high in the cycle after the last bit
            read_complete <= (bit_cnt == CNT_W'(1));
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rd_valid)
      begin
         shift_reg <= rd_data;
      end
      else if (sdo_valid)
      begin
         shift_reg <= {shift_reg[WORD_W-2:0], 1'b0};
      end
   end

endmodule

/* hw/sample_buffer.sv */
`timescale 1ns/1ps

module sample_buffer
   import capture_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                sample_valid,   // single-cycle strobe, no back-pressure
   input  logic [SAMPLE_W-1:0] sample_data,
   input  logic [BUF_AW-1:0]   buf_rd_addr,
   output logic [BUF_AW-1:0]   buf_wr_addr,
   output logic [SAMPLE_W-1:0] buf_rd_data
);

   localparam int DEPTH = 2**BUF_AW;

   logic [SAMPLE_W-1:0] mem [DEPTH];

   // write pointer wraps on its own at 512
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         buf_wr_addr <= '0;
      end
      else if (sample_valid)
      begin
         buf_wr_addr <= buf_wr_addr + 1'b1;
      end
   end

   // array write and registered read port
   always_ff @(posedge clk)
   begin
      if (sample_valid)
      begin
         mem[buf_wr_addr] <= sample_data;
      end
      buf_rd_data <= mem[buf_rd_addr];   // valid one cycle after the address
   end

endmodule

/* hw/sdram_store.sv */
`timescale 1ns/1ps

module sdram_store
   import capture_pkg::*;
#(
   parameter int SDRAM_AW      = 6,
   parameter int SDRAM_LATENCY = 3
)
(
   input  logic                clk,
   input  logic                rst,
   input  logic                cmd_enable,
   input  sdram_op_e           cmd_op,
   input  logic [SDRAM_AW-2:0] cmd_addr,
   input  logic [WORD_W-1:0]   cmd_wdata,
   output logic                cmd_ready,
   output logic                rd_valid,
   output logic [WORD_W-1:0]   rd_data
);

   localparam int DEPTH = 2**(SDRAM_AW-1);
   localparam int CNT_W = $clog2(SDRAM_LATENCY+1);

   logic [WORD_W-1:0]   mem [DEPTH];
   logic [CNT_W-1:0]    busy_cnt;
   sdram_op_e           pend_op;
   logic [SDRAM_AW-2:0] pend_addr;
   logic [WORD_W-1:0]   pend_wdata;
   logic                accept;
   logic                finish;

   assign accept = cmd_enable && cmd_ready;
   assign finish = !cmd_ready && (busy_cnt == CNT_W'(1));   // last latency cycle

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cmd_ready <= 1'b1;
         rd_valid  <= 1'b0;
         busy_cnt  <= '0;
         pend_op   <= OP_READ;
      end
      else
      begin
         rd_valid <= 1'b0;
         if (accept)
         begin
            cmd_ready <= 1'b0;
            busy_cnt  <= CNT_W'(SDRAM_LATENCY);
            pend_op   <= cmd_op;
         end
         else if (finish)
         begin
            cmd_ready <= 1'b1;   // free again on the same edge as the read return
            busy_cnt  <= '0;
            rd_valid  <= (pend_op == OP_READ);
         end
         else if (!cmd_ready)
         begin
            busy_cnt <= busy_cnt - 1'b1;
         end
      end
   end

   // command capture and array access
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         pend_addr  <= cmd_addr;
         pend_wdata <= cmd_wdata;
      end
      if (finish && pend_op == OP_WRITE)
      begin
         mem[pend_addr] <= pend_wdata;
      end
      if (finish && pend_op == OP_READ)
      begin
         rd_data <= mem[pend_addr];
      end
   end

endmodule
